// ==== hdl/bypass_ctrl.sv ====
// Combinational hazard unit; assumes load data is only available from WB, never from EX
`timescale 1ns/100ps
`default_nettype none

module bypass_ctrl (
  input  pipe_pkg::if_id_t     if_id_i,
  input  pipe_pkg::id_ex_t     id_ex_i,
  input  pipe_pkg::ex_wb_t     ex_wb_i,
  input  logic [1:0]           rf_re_i,
  input  pipe_pkg::rf_addr_t   rf_raddr_i [2],
  output pipe_pkg::ctrl_byp_t  ctrl_byp_o
);
  import pipe_pkg::*;

  logic [1:0] rf_rd_ex_match;
  logic [1:0] rf_rd_wb_match;
  logic       rf_we_ex;
  logic       rf_we_wb;
  logic       load_in_ex;

  // Qualified writers in EX and WB
  assign rf_we_ex   = id_ex_i.instr_valid && id_ex_i.rf_we;
  assign rf_we_wb   = ex_wb_i.instr_valid && ex_wb_i.rf_we;
  assign load_in_ex = rf_we_ex && id_ex_i.lsu_en;

  ////////////////////////////////////////////////////////////
  // Address match per read port
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 2; i++) begin : gen_match
    // x0 never matches
    assign rf_rd_ex_match[i] = if_id_i.instr_valid && rf_re_i[i] && (|rf_raddr_i[i])
                               && rf_we_ex && (id_ex_i.rf_waddr == rf_raddr_i[i]);
    assign rf_rd_wb_match[i] = if_id_i.instr_valid && rf_re_i[i] && (|rf_raddr_i[i])
                               && rf_we_wb && (ex_wb_i.rf_waddr == rf_raddr_i[i]);
  end

  ////////////////////////////////////////////////////////////
  // Load-use stall
  ////////////////////////////////////////////////////////////

  // One cycle is enough, the load then sits in WB
  assign ctrl_byp_o.load_stall = load_in_ex && (|rf_rd_ex_match);

  ////////////////////////////////////////////////////////////
  // Forwarding select
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_byp_o.operand_a_fw_sel = SEL_REGFILE;
    ctrl_byp_o.operand_b_fw_sel = SEL_REGFILE;

    // WB first, EX overrides as the younger result
    if (rf_rd_wb_match[0]) begin
      ctrl_byp_o.operand_a_fw_sel = SEL_FW_WB;
    end
    if (rf_rd_wb_match[1]) begin
      ctrl_byp_o.operand_b_fw_sel = SEL_FW_WB;
    end

    // No EX source while a load is there, stall covers it
    if (!load_in_ex) begin
      if (rf_rd_ex_match[0]) begin
        ctrl_byp_o.operand_a_fw_sel = SEL_FW_EX;
      end
      if (rf_rd_ex_match[1]) begin
        ctrl_byp_o.operand_b_fw_sel = SEL_FW_EX;
      end
    end
  end

  // Deferred check, there is no clock here
  always_comb begin
    a_no_ex_fw_on_load : assert final (!(load_in_ex &&
      ((ctrl_byp_o.operand_a_fw_sel == SEL_FW_EX) ||
       (ctrl_byp_o.operand_b_fw_sel == SEL_FW_EX))))
      else $error("EX forwarding selected with a load in EX");
  end

endmodule

`default_nettype wire

// ==== hdl/exec_pipe.sv ====
// ID, EX and WB stages; load/store must always win the RAM, undefined opcodes retire as no-ops
`timescale 1ns/100ps
`default_nettype none

`include "pipe_params.svh"

module exec_pipe (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  pipe_pkg::if_id_t     if_id_i,
  input  pipe_pkg::ctrl_byp_t  ctrl_byp_i,
  output pipe_pkg::id_ex_t     id_ex_o,
  output pipe_pkg::ex_wb_t     ex_wb_o,
  output logic [1:0]           rf_re_o,
  output pipe_pkg::rf_addr_t   rf_raddr_o [2],
  mem_bus_if.requester         bus,
  output logic                 retire_valid_o,
  output pipe_pkg::rf_addr_t   retire_rd_o,
  output pipe_pkg::word_t      retire_data_o,
  output logic                 retire_halt_o
);
  import pipe_pkg::*;

  instr_u    instr;
  opcode_e   opcode;
  rf_addr_t  rd_id;
  word_t     imm_sext;
  logic      writes_rd;
  logic      use_imm;
  logic      lsu_en_id;
  logic      lsu_we_id;
  logic      halt_id;
  logic      halt_ex_q;
  logic      halt_wb_q;
  fw_sel_e   fw_sel [2];
  word_t     operand [2];
  word_t     rf_q [`PIPE_NREGS];
  word_t     alu_result_ex;
  word_t     wb_data;

  ////////////////////////////////////////////////////////////
  // ID decode, both layouts of the same word
  ////////////////////////////////////////////////////////////

  assign instr    = if_id_i.instr;
  assign opcode   = instr.r_fmt.opcode;
  assign rd_id    = instr.i_fmt.rd;
  assign imm_sext = word_t'(instr.i_fmt.imm);

  always_comb begin
    rf_re_o       = 2'b00;
    rf_raddr_o[0] = instr.i_fmt.rs1;
    rf_raddr_o[1] = instr.r_fmt.rs2;
    writes_rd     = 1'b0;
    use_imm       = 1'b0;
    lsu_en_id     = 1'b0;
    lsu_we_id     = 1'b0;
    halt_id       = 1'b0;
    case (opcode)
      OP_ADD: begin
        rf_re_o   = 2'b11;
        writes_rd = 1'b1;
      end
      OP_ADDI: begin
        rf_re_o   = 2'b01;
        writes_rd = 1'b1;
        use_imm   = 1'b1;
      end
      OP_LW: begin
        rf_re_o   = 2'b01;
        writes_rd = 1'b1;
        use_imm   = 1'b1;
        lsu_en_id = 1'b1;
      end
      OP_SW: begin
        // Store data comes through read port 1 from rd
        rf_re_o       = 2'b11;
        rf_raddr_o[1] = rd_id;
        use_imm       = 1'b1;
        lsu_en_id     = 1'b1;
        lsu_we_id     = 1'b1;
      end
      OP_HALT: begin
        halt_id = 1'b1;
      end
      default: ;
    endcase
  end

  // Operand muxes, x0 reads zero
  assign fw_sel[0] = ctrl_byp_i.operand_a_fw_sel;
  assign fw_sel[1] = ctrl_byp_i.operand_b_fw_sel;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      case (fw_sel[i])
        SEL_FW_EX: operand[i] = alu_result_ex;
        SEL_FW_WB: operand[i] = wb_data;
        default:   operand[i] = (rf_raddr_o[i] == '0) ? '0 : rf_q[rf_raddr_o[i]];
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // ID/EX and EX/WB registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_o   <= '0;
      ex_wb_o   <= '0;
      halt_ex_q <= 1'b0;
      halt_wb_q <= 1'b0;
    end else begin
      // Stall leaves a bubble in EX
      id_ex_o.instr_valid <= if_id_i.instr_valid && !ctrl_byp_i.load_stall;
      id_ex_o.rf_we       <= writes_rd && (|rd_id);
      id_ex_o.rf_waddr    <= rd_id;
      id_ex_o.lsu_en      <= lsu_en_id;
      id_ex_o.lsu_we      <= lsu_we_id;
      id_ex_o.op_a        <= operand[0];
      id_ex_o.op_b        <= use_imm ? imm_sext : operand[1];
      id_ex_o.store_data  <= operand[1];
      halt_ex_q           <= halt_id;

      ex_wb_o.instr_valid <= id_ex_o.instr_valid;
      ex_wb_o.rf_we       <= id_ex_o.rf_we;
      ex_wb_o.rf_waddr    <= id_ex_o.rf_waddr;
      ex_wb_o.lsu_en      <= id_ex_o.lsu_en;
      ex_wb_o.alu_result  <= alu_result_ex;
      halt_wb_q           <= halt_ex_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // EX, ALU and memory request
  ////////////////////////////////////////////////////////////

  // Sum serves ADD, ADDI and the load/store address
  assign alu_result_ex = id_ex_o.op_a + id_ex_o.op_b;

  assign bus.req   = id_ex_o.instr_valid && id_ex_o.lsu_en;
  assign bus.we    = id_ex_o.lsu_we;
  assign bus.addr  = ram_addr_t'(alu_result_ex);
  assign bus.wdata = id_ex_o.store_data;

  ////////////////////////////////////////////////////////////
  // WB and retire
  ////////////////////////////////////////////////////////////

  // Load data returns the cycle after the EX grant
  assign wb_data = ex_wb_o.lsu_en ? bus.rdata : ex_wb_o.alu_result;

  always_ff @(posedge clk_i) begin
    if (ex_wb_o.instr_valid && ex_wb_o.rf_we) begin
      rf_q[ex_wb_o.rf_waddr] <= wb_data;
    end
  end

  // SW, HALT and x0 writes show rd and data as zero
  assign retire_valid_o = ex_wb_o.instr_valid;
  assign retire_rd_o    = ex_wb_o.rf_we ? ex_wb_o.rf_waddr : '0;
  assign retire_data_o  = ex_wb_o.rf_we ? wb_data : '0;
  assign retire_halt_o  = ex_wb_o.instr_valid && halt_wb_q;

  // Arbiter priority is what lets WB never wait
  a_lsu_granted : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) bus.req |-> bus.gnt
  ) else $error("load/store request not granted");

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
// One fetch in flight at a time; words returned after HALT are dropped, start_i ignored while running
`timescale 1ns/100ps
`default_nettype none

`include "pipe_params.svh"

module fetch_unit (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 start_i,
  input  logic                 retire_halt_i,
  input  pipe_pkg::ctrl_byp_t  ctrl_byp_i,
  mem_bus_if.requester         bus,
  output pipe_pkg::if_id_t     if_id_o,
  output logic                 halted_o
);
  import pipe_pkg::*;

  logic       running_q;
  logic       halt_seen_q;
  logic       pending_q;
  logic       skid_valid_q;
  logic       start_ok;
  logic       halt_back;
  ram_addr_t  pc_q;
  ram_addr_t  pend_pc_q;
  if_id_t     skid_q;
  if_id_t     fetched;

  assign start_ok = start_i && !running_q;

  // Fetch is read only
  assign bus.req   = running_q && !halt_seen_q;
  assign bus.we    = 1'b0;
  assign bus.addr  = pc_q;
  assign bus.wdata = '0;

  // Word coming back from last cycle's grant
  assign fetched.instr_valid = pending_q && !halt_seen_q;
  assign fetched.pc          = pend_pc_q;
  assign fetched.instr       = bus.rdata;

  assign halt_back = fetched.instr_valid && (fetched.instr.r_fmt.opcode == OP_HALT);

  ////////////////////////////////////////////////////////////
  // PC and run control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      running_q   <= 1'b0;
      halt_seen_q <= 1'b0;
      pending_q   <= 1'b0;
      halted_o    <= 1'b0;
      pc_q        <= ram_addr_t'(`PIPE_RESET_PC);
      pend_pc_q   <= ram_addr_t'(`PIPE_RESET_PC);
    end else begin
      pending_q <= bus.gnt;
      pend_pc_q <= pc_q;
      // A lost grant just holds the PC
      if (bus.gnt) begin
        pc_q <= pc_q + 1'b1;
      end
      if (halt_back) begin
        halt_seen_q <= 1'b1;
      end
      if (start_ok) begin
        running_q   <= 1'b1;
        halted_o    <= 1'b0;
        halt_seen_q <= 1'b0;
        pc_q        <= ram_addr_t'(`PIPE_RESET_PC);
      end else if (retire_halt_i) begin
        running_q <= 1'b0;
        halted_o  <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // IF/ID register with one skid entry
  ////////////////////////////////////////////////////////////

  // A stall only happens with a load in EX, which owns the RAM,
  // so at most one word lands in the skid per stall
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_id_o      <= '0;
      skid_q       <= '0;
      skid_valid_q <= 1'b0;
    end else if (ctrl_byp_i.load_stall) begin
      if (fetched.instr_valid) begin
        skid_q       <= fetched;
        skid_valid_q <= 1'b1;
      end
    end else begin
      if_id_o      <= skid_valid_q ? skid_q : fetched;
      skid_valid_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
// Fixed priority, load/store always wins; rdata is only meaningful the cycle after a read grant
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  mem_bus_if.arbiter           fetch_bus,
  mem_bus_if.arbiter           lsu_bus,
  output logic                 ram_req_o,
  output logic                 ram_we_o,
  output pipe_pkg::ram_addr_t  ram_addr_o,
  output pipe_pkg::word_t      ram_wdata_o,
  input  pipe_pkg::word_t      ram_rdata_i
);
  import pipe_pkg::*;

  // Owner of the read data coming back this cycle, 1 for load/store
  logic owner_lsu_q;

  ////////////////////////////////////////////////////////////
  // Grant
  ////////////////////////////////////////////////////////////

  assign lsu_bus.gnt   = lsu_bus.req;
  assign fetch_bus.gnt = fetch_bus.req && !lsu_bus.req;

  // RAM access port follows the winner
  assign ram_req_o   = lsu_bus.req || fetch_bus.req;
  assign ram_we_o    = lsu_bus.req ? lsu_bus.we    : fetch_bus.we;
  assign ram_addr_o  = lsu_bus.req ? lsu_bus.addr  : fetch_bus.addr;
  assign ram_wdata_o = lsu_bus.req ? lsu_bus.wdata : fetch_bus.wdata;

  ////////////////////////////////////////////////////////////
  // Read data return
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owner_lsu_q <= 1'b0;
    end else begin
      owner_lsu_q <= lsu_bus.gnt;
    end
  end

  // The loser sees zeros
  assign lsu_bus.rdata   = owner_lsu_q  ? ram_rdata_i : '0;
  assign fetch_bus.rdata = !owner_lsu_q ? ram_rdata_i : '0;

  a_one_grant : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(fetch_bus.gnt && lsu_bus.gnt)
  ) else $error("both requesters granted");

endmodule

`default_nettype wire

// ==== hdl/mem_bus_if.sv ====
// One requester's RAM port; requester holds req and payload until gnt, read data one cycle later
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if;
  import pipe_pkg::*;

  // Request side, held stable until granted
  logic       req;
  logic       we;
  ram_addr_t  addr;
  word_t      wdata;

  // Same-cycle grant, registered read data
  logic       gnt;
  word_t      rdata;

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

`default_nettype wire

// ==== hdl/mini_core_top.sv ====
// Core with shared RAM; drive load_we_i only while idle, start_i is ignored while running
`timescale 1ns/100ps
`default_nettype none

`include "pipe_params.svh"

module mini_core_top (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               start_i,
  input  logic                               load_we_i,
  input  logic [$clog2(`PIPE_RAM_WORDS)-1:0] load_addr_i,
  input  logic [`PIPE_XLEN-1:0]              load_data_i,
  output logic                               retire_valid_o,
  output logic [$clog2(`PIPE_NREGS)-1:0]     retire_rd_o,
  output logic [`PIPE_XLEN-1:0]              retire_data_o,
  output logic                               halted_o
);
  import pipe_pkg::*;

  // Pipeline registers and hazard control
  if_id_t     if_id;
  id_ex_t     id_ex;
  ex_wb_t     ex_wb;
  ctrl_byp_t  ctrl_byp;
  logic [1:0] rf_re;
  rf_addr_t   rf_raddr [2];
  logic       retire_halt;

  // RAM access port
  logic       ram_req;
  logic       ram_we;
  ram_addr_t  ram_addr;
  word_t      ram_wdata;
  word_t      ram_rdata;

  mem_bus_if fetch_bus ();
  mem_bus_if lsu_bus ();

  fetch_unit fetch_unit_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (start_i),
    .retire_halt_i (retire_halt),
    .ctrl_byp_i    (ctrl_byp),
    .bus           (fetch_bus.requester),
    .if_id_o       (if_id),
    .halted_o      (halted_o)
  );

  exec_pipe exec_pipe_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .if_id_i        (if_id),
    .ctrl_byp_i     (ctrl_byp),
    .id_ex_o        (id_ex),
    .ex_wb_o        (ex_wb),
    .rf_re_o        (rf_re),
    .rf_raddr_o     (rf_raddr),
    .bus            (lsu_bus.requester),
    .retire_valid_o (retire_valid_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o),
    .retire_halt_o  (retire_halt)
  );

  bypass_ctrl bypass_ctrl_inst (
    .if_id_i    (if_id),
    .id_ex_i    (id_ex),
    .ex_wb_i    (ex_wb),
    .rf_re_i    (rf_re),
    .rf_raddr_i (rf_raddr),
    .ctrl_byp_o (ctrl_byp)
  );

  mem_arbiter mem_arbiter_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .fetch_bus   (fetch_bus.arbiter),
    .lsu_bus     (lsu_bus.arbiter),
    .ram_req_o   (ram_req),
    .ram_we_o    (ram_we),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata),
    .ram_rdata_i (ram_rdata)
  );

  shared_ram shared_ram_inst (
    .clk_i       (clk_i),
    .req_i       (ram_req),
    .we_i        (ram_we),
    .addr_i      (ram_addr),
    .wdata_i     (ram_wdata),
    .rdata_o     (ram_rdata),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i)
  );

endmodule

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
// Types for the four-stage core; instruction layouts assume NREGS of 8 and XLEN of 32
`default_nettype none

`include "pipe_params.svh"

package pipe_pkg;

  localparam int unsigned RF_AW  = $clog2(`PIPE_NREGS);
  localparam int unsigned RAM_AW = $clog2(`PIPE_RAM_WORDS);

  typedef logic [`PIPE_XLEN-1:0] word_t;
  typedef logic [RF_AW-1:0]      rf_addr_t;
  typedef logic [RAM_AW-1:0]     ram_addr_t;

  // Opcode sits in the top four bits of every instruction
  typedef enum logic [3:0] {
    OP_ADD  = 4'h1,
    OP_ADDI = 4'h2,
    OP_LW   = 4'h3,
    OP_SW   = 4'h4,
    OP_HALT = 4'hF
  } opcode_e;

  // Register-register layout
  typedef struct packed {
    opcode_e                          opcode;
    rf_addr_t                         rd;
    rf_addr_t                         rs1;
    rf_addr_t                         rs2;
    logic [`PIPE_XLEN-4-3*RF_AW-1:0]  unused;
  } r_fmt_t;

  // Immediate layout where SW takes its store data from the rd field
  typedef struct packed {
    opcode_e                             opcode;
    rf_addr_t                            rd;
    rf_addr_t                            rs1;
    logic [`PIPE_XLEN-4-2*RF_AW-16-1:0]  pad;
    logic signed [15:0]                  imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

  // Operand source in ID
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  typedef struct packed {
    logic       instr_valid;
    ram_addr_t  pc;
    instr_u     instr;
  } if_id_t;

  typedef struct packed {
    logic      instr_valid;
    logic      rf_we;
    rf_addr_t  rf_waddr;
    logic      lsu_en;
    logic      lsu_we;
    word_t     op_a;
    word_t     op_b;
    word_t     store_data;
  } id_ex_t;

  typedef struct packed {
    logic      instr_valid;
    logic      rf_we;
    rf_addr_t  rf_waddr;
    logic      lsu_en;
    word_t     alu_result;
  } ex_wb_t;

  typedef struct packed {
    logic     load_stall;
    fw_sel_e  operand_a_fw_sel;
    fw_sel_e  operand_b_fw_sel;
  } ctrl_byp_t;

endpackage

`default_nettype wire

// ==== hdl/shared_ram.sv ====
// Single port, no reset on contents; the load port may only be used while the core is idle
`timescale 1ns/100ps
`default_nettype none

`include "pipe_params.svh"

module shared_ram (
  input  logic                 clk_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  pipe_pkg::ram_addr_t  addr_i,
  input  pipe_pkg::word_t      wdata_i,
  output pipe_pkg::word_t      rdata_o,
  input  logic                 load_we_i,
  input  pipe_pkg::ram_addr_t  load_addr_i,
  input  pipe_pkg::word_t      load_data_i
);
  import pipe_pkg::*;

  word_t mem_q [`PIPE_RAM_WORDS];

  always_ff @(posedge clk_i) begin
    // Test load port first, bus writes otherwise
    if (load_we_i) begin
      mem_q[load_addr_i] <= load_data_i;
    end else if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    // Registered read, one cycle latency
    if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

  a_load_idle : assert property (
    @(posedge clk_i) !(load_we_i && req_i)
  ) else $error("load port used during a bus access");

endmodule

`default_nettype wire

// ==== include/pipe_params.svh ====
// Sizes shared by RTL and testbench; RAM and register counts must stay powers of two
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// Data and instruction word width
`define PIPE_XLEN 32

// Register count, x0 reads as zero
`define PIPE_NREGS 8

// RAM depth in words, shared by code and data
`define PIPE_RAM_WORDS 256

// Word address of the first fetch after start
`define PIPE_RESET_PC 0

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator, pass only on the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_mini_core -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_mini_core)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^TEST PASSED$'; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== tb.f ====
+incdir+include
hdl/pipe_pkg.sv
hdl/mem_bus_if.sv
hdl/mem_arbiter.sv
hdl/shared_ram.sv
hdl/fetch_unit.sv
hdl/bypass_ctrl.sv
hdl/exec_pipe.sv
hdl/mini_core_top.sv
tb/tb_mini_core.sv

// ==== tb/tb_mini_core.sv ====
// Program must end in HALT and fit below the data words at 0x80; data words drawn with seed 75
`timescale 1ns/100ps
`default_nettype none

`include "pipe_params.svh"

module tb_mini_core;

  localparam int RF_AW        = $clog2(`PIPE_NREGS);
  localparam int RAM_AW       = $clog2(`PIPE_RAM_WORDS);
  localparam int RESET_CYCLES = 16;
  localparam int PROG_LEN     = 19;
  localparam int TIMEOUT      = PROG_LEN * 8 + RESET_CYCLES;

  // Opcodes as the ISA defines them in the top four bits of the word
  localparam logic [3:0] OPC_ADD  = 4'h1;
  localparam logic [3:0] OPC_ADDI = 4'h2;
  localparam logic [3:0] OPC_LW   = 4'h3;
  localparam logic [3:0] OPC_SW   = 4'h4;
  localparam logic [3:0] OPC_HALT = 4'hF;

  // Data words live well above the code
  localparam logic [15:0] DATA_A  = 16'h0080;
  localparam logic [15:0] DATA_B  = 16'h0081;
  localparam logic [15:0] STORE_A = 16'h0090;
  localparam logic [15:0] STORE_B = 16'h0091;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  start_i;
  logic                  load_we_i;
  logic [RAM_AW-1:0]     load_addr_i;
  logic [`PIPE_XLEN-1:0] load_data_i;
  logic                  retire_valid_o;
  logic [RF_AW-1:0]      retire_rd_o;
  logic [`PIPE_XLEN-1:0] retire_data_o;
  logic                  halted_o;

  // Program word, expected rd and expected data per row
  logic [`PIPE_XLEN-1:0] prog_word [PROG_LEN];
  logic [RF_AW-1:0]      exp_rd    [PROG_LEN];
  logic [`PIPE_XLEN-1:0] exp_data  [PROG_LEN];
  int                    row_cnt;
  int                    retire_cnt;
  int                    cycle_cnt;
  logic [`PIPE_XLEN-1:0] rand_a;
  logic [`PIPE_XLEN-1:0] rand_b;

  mini_core_top mini_core_top_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .start_i        (start_i),
    .load_we_i      (load_we_i),
    .load_addr_i    (load_addr_i),
    .load_data_i    (load_data_i),
    .retire_valid_o (retire_valid_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o),
    .halted_o       (halted_o)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // R layout with opcode, rd, rs1, rs2 and zero fill
  function automatic logic [`PIPE_XLEN-1:0] r_format_word(input logic [3:0] op,
    input logic [RF_AW-1:0] rd, input logic [RF_AW-1:0] rs1, input logic [RF_AW-1:0] rs2);
    return {op, rd, rs1, rs2, {(`PIPE_XLEN-4-3*RF_AW){1'b0}}};
  endfunction

  // I layout with opcode, rd, rs1, pad and a 16-bit immediate
  function automatic logic [`PIPE_XLEN-1:0] i_format_word(input logic [3:0] op,
    input logic [RF_AW-1:0] rd, input logic [RF_AW-1:0] rs1, input logic [15:0] imm);
    return {op, rd, rs1, {(`PIPE_XLEN-4-2*RF_AW-16){1'b0}}, imm};
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [`PIPE_XLEN-1:0] got,
    input logic [`PIPE_XLEN-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic add_row(input logic [`PIPE_XLEN-1:0] word, input logic [RF_AW-1:0] rd,
    input logic [`PIPE_XLEN-1:0] data);
    prog_word[row_cnt] = word;
    exp_rd[row_cnt]    = rd;
    exp_data[row_cnt]  = data;
    row_cnt++;
  endtask

  // Expected values worked out from the ISA where x0 writes, SW and HALT retire as zero
  task automatic build_table();
    row_cnt = 0;
    // Dependent chain through EX forwarding
    add_row(i_format_word(OPC_ADDI, 3'd1, 3'd0, 16'd5), 3'd1, 32'd5);
    add_row(i_format_word(OPC_ADDI, 3'd2, 3'd1, 16'd7), 3'd2, 32'd12);
    add_row(r_format_word(OPC_ADD, 3'd3, 3'd2, 3'd1), 3'd3, 32'd17);
    add_row(r_format_word(OPC_ADD, 3'd3, 3'd3, 3'd3), 3'd3, 32'd34);
    // WB forwarding over one independent instruction
    add_row(i_format_word(OPC_ADDI, 3'd4, 3'd0, 16'hFFFD), 3'd4, 32'hFFFF_FFFD);
    add_row(i_format_word(OPC_ADDI, 3'd5, 3'd1, 16'd100), 3'd5, 32'd105);
    add_row(r_format_word(OPC_ADD, 3'd6, 3'd4, 3'd3), 3'd6, 32'd31);
    // Load then immediate use
    add_row(i_format_word(OPC_LW, 3'd1, 3'd0, DATA_A), 3'd1, rand_a);
    add_row(r_format_word(OPC_ADD, 3'd2, 3'd1, 3'd5), 3'd2, rand_a + 32'd105);
    // Store and reload with store data hazards on a load and an ALU result
    add_row(i_format_word(OPC_LW, 3'd7, 3'd0, DATA_B), 3'd7, rand_b);
    add_row(i_format_word(OPC_SW, 3'd7, 3'd0, STORE_A), 3'd0, 32'd0);
    add_row(i_format_word(OPC_LW, 3'd6, 3'd0, STORE_A), 3'd6, rand_b);
    add_row(i_format_word(OPC_SW, 3'd2, 3'd0, STORE_B), 3'd0, 32'd0);
    add_row(i_format_word(OPC_LW, 3'd5, 3'd0, STORE_B), 3'd5, rand_a + 32'd105);
    add_row(r_format_word(OPC_ADD, 3'd4, 3'd6, 3'd5), 3'd4, rand_b + rand_a + 32'd105);
    // x0 stays zero and never forwards
    add_row(i_format_word(OPC_ADDI, 3'd0, 3'd1, 16'd9), 3'd0, 32'd0);
    add_row(r_format_word(OPC_ADD, 3'd0, 3'd3, 3'd3), 3'd0, 32'd0);
    add_row(r_format_word(OPC_ADD, 3'd7, 3'd0, 3'd3), 3'd7, 32'd34);
    add_row({OPC_HALT, {(`PIPE_XLEN-4){1'b0}}}, 3'd0, 32'd0);
  endtask

  // One RAM word through the load port that lands at the next edge
  task automatic preload_word(input logic [RAM_AW-1:0] addr, input logic [`PIPE_XLEN-1:0] data);
    @(posedge clk_i);
    #1;
    load_we_i   = 1'b1;
    load_addr_i = addr;
    load_data_i = data;
  endtask

  ////////////////////////////////////////////////////////////
  // Clock, timeout and retire monitor
  ////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT) begin
      fail_run($sformatf("timeout after %0d cycles with %0d retires", cycle_cnt, retire_cnt));
    end
  end

  // Sample mid cycle where retire outputs are settled
  always @(negedge clk_i) begin
    if (retire_valid_o) begin
      if (retire_cnt >= PROG_LEN) begin
        fail_run("an instruction retired after the last table row");
      end
      check_value("retire_rd_o", 32'(retire_rd_o), 32'(exp_rd[retire_cnt]));
      check_value("retire_data_o", retire_data_o, exp_data[retire_cnt]);
      retire_cnt++;
    end
    if (halted_o && retire_cnt != PROG_LEN) begin
      fail_run("halted_o rose before HALT retired");
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    cycle_cnt   = 0;
    retire_cnt  = 0;
    rst_n_i     = 1'b0;
    start_i     = 1'b0;
    load_we_i   = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    void'($urandom(75));
    rand_a = $urandom;
    rand_b = $urandom;
    build_table();
    if (row_cnt != PROG_LEN) begin
      fail_run("program table length does not match PROG_LEN");
    end

    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Code from word 0 followed by the two data words
    for (int i = 0; i < PROG_LEN; i++) begin
      preload_word(RAM_AW'(i), prog_word[i]);
    end
    preload_word(DATA_A[RAM_AW-1:0], rand_a);
    preload_word(DATA_B[RAM_AW-1:0], rand_b);
    @(posedge clk_i);
    #1;
    load_we_i = 1'b0;

    @(posedge clk_i);
    #1;
    start_i = 1'b1;
    @(posedge clk_i);
    #1;
    start_i = 1'b0;

    // Timeout covers a core that never halts
    while (halted_o !== 1'b1) begin
      @(negedge clk_i);
    end
    // Quiet cycles in which nothing may retire after HALT
    repeat (4) @(posedge clk_i);
    #1;
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
